//--- list.f
src/avr_link_pkg.sv
src/spi_link_if.sv
src/spi_line_sync.sv
src/avr_slave_regs.sv
src/sd_byte_xfer.sv
src/evo_avr_link.sv
testbench/avr_link_checker.sv
testbench/avr_link_props.sv
testbench/tb_evo_avr_link.sv

//--- Bender.yml
package:
  name: evo_avr_link

sources:
  - files:
      - src/avr_link_pkg.sv
      - src/spi_link_if.sv
      - src/spi_line_sync.sv
      - src/avr_slave_regs.sv
      - src/sd_byte_xfer.sv
      - src/evo_avr_link.sv
  - target: test
    files:
      - testbench/avr_link_checker.sv
      - testbench/avr_link_props.sv
      - testbench/tb_evo_avr_link.sv

//--- testbench/tb_evo_avr_link.sv
// testbench for the avr link
// avr master tasks, random register traffic, behavioral sd card
`timescale 1ns/1ps
`default_nettype none

module tb_evo_avr_link;

	localparam int HALF    = 6;                       // avr sck half period, fclk cycles
	localparam int WORST   = (8 + 40) * 2 * HALF + 4 * HALF;
	localparam int TIMEOUT = 40 * WORST + 2000;       // about 40 transfers in all

	logic                    fclk, rst_n, spics_n, spick, spido, spidi;
	avr_link_pkg::byte_t     status_in, status_prev, mus_out, config0;
	avr_link_pkg::kbd_word_t kbd_out;
	logic                    kbd_stb, mus_xstb, mus_ystb, mus_btnstb, kj_stb, genrst;
	logic                    sd_cs_n, sd_sck, sd_mosi, sd_miso;
	avr_link_pkg::byte_t     sd_reply, mosi_seen;
	logic [2:0]              fall_cnt;
	logic [31:0]             rng;
	int                      cycles;

	evo_avr_link #(.SD_DIV (2)) u_evo_avr_link
	(
		.fclk (fclk), .rst_n (rst_n), .spics_n (spics_n), .spick (spick),
		.spido (spido), .spidi (spidi), .status_in (status_in),
		.kbd_out (kbd_out), .kbd_stb (kbd_stb), .mus_out (mus_out),
		.mus_xstb (mus_xstb), .mus_ystb (mus_ystb), .mus_btnstb (mus_btnstb),
		.kj_stb (kj_stb), .genrst (genrst), .config0 (config0),
		.sd_cs_n (sd_cs_n), .sd_sck (sd_sck), .sd_mosi (sd_mosi), .sd_miso (sd_miso)
	);

	avr_link_checker u_check
	(
		.fclk (fclk), .rst_n (rst_n), .kbd_out (kbd_out), .kbd_stb (kbd_stb),
		.mus_out (mus_out), .mus_xstb (mus_xstb), .mus_ystb (mus_ystb),
		.mus_btnstb (mus_btnstb), .kj_stb (kj_stb), .genrst (genrst),
		.config0 (config0), .sd_cs_n (sd_cs_n)
	);

	initial
	begin
		fclk = 1'b0;
		forever #2 fclk = ~fclk;
	end

	always @(posedge fclk)
	begin
		cycles++;
		if (cycles >= TIMEOUT)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// sd card: reply msb first, next bit after each falling sck
	assign sd_miso = sd_reply[3'd7 - fall_cnt];
	always @(negedge sd_sck)
		if (rst_n)
			fall_cnt = fall_cnt + 3'd1;
	always @(posedge sd_sck)
		if (rst_n)
			mosi_seen = {mosi_seen[6:0], sd_mosi}; // card samples on rise

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// strobe bit expected from a register number, kbd first, genrst last
	function automatic logic [5:0] commit_mask(input avr_link_pkg::reg_num_t num);
		case (num)
			avr_link_pkg::REG_KBD_STB: return 6'b100000;
			avr_link_pkg::REG_MUS_X:   return 6'b010000;
			avr_link_pkg::REG_MUS_Y:   return 6'b001000;
			avr_link_pkg::REG_MUS_BTN: return 6'b000100;
			avr_link_pkg::REG_KJ:      return 6'b000010;
			avr_link_pkg::REG_RST:     return 6'b000001;
			default:                   return 6'b000000;
		endcase
	endfunction

	task automatic step(input int n);
		repeat (n) @(posedge fclk);
		#0.5;
	endtask

	// lsb first, spidi taken at the end of each low half
	task automatic send_bits(input logic [39:0] data, input int nbits, output logic [39:0] got);
		got = '0;
		for (int i = 0; i < nbits; i++)
		begin
			spido = data[i];
			step(HALF);
			got[i] = spidi;
			spick = 1'b1;
			step(HALF);
			spick = 1'b0;
		end
	endtask

	// drive a new status and let cs go high, which commits
	task automatic release_cs();
		step(HALF);
		rng         = xorshift(rng);
		status_in   = rng[7:0];
		status_prev = rng[7:0];
		spics_n     = 1'b1;
		step(HALF);
	endtask

	task automatic transfer(input avr_link_pkg::reg_num_t num, input logic [39:0] data,
		input int nbits, output logic [39:0] rd);
		logic [39:0] st;
		send_bits({32'd0, num}, 8, st);
		u_check.compare("status", {32'd0, status_prev}, {32'd0, st[7:0]});
		spics_n = 1'b0;
		send_bits(data, nbits, rd);
		release_cs();
	endtask

	task automatic sd_wait_idle();
		logic [39:0] rd;
		int          n;
		n = 0;
		do
		begin
			transfer(avr_link_pkg::REG_SD_CTRL, 40'd0, 8, rd); // keeps cs_n low
			u_check.expect_commit(6'd0, 8'd0);
			n++;
		end
		while (rd[7] && n < 10);
		if (rd[7])
			u_check.fail_msg("sd exchanger stayed busy");
	endtask

	initial
	begin
		logic [39:0]         rd;
		logic [39:0]         word;
		avr_link_pkg::byte_t b;
		avr_link_pkg::reg_num_t num;
		rst_n = 1'b0;
		spics_n = 1'b1;
		spick = 1'b0;
		spido = 1'b0;
		status_in = '0;
		status_prev = '0;
		sd_reply = '0;
		mosi_seen = '0;
		fall_cnt = '0;
		cycles = 0;
		rng = 32'h5d9e_6eca;
		repeat (8) @(posedge fclk);
		#0.5 rst_n = 1'b1;
		step(4);

		u_check.start_test("reset_idle");
		u_check.expect_commit(6'd0, 8'd0);
		spics_n = 1'b0; // empty transfer loads the first status
		release_cs();
		u_check.expect_commit(6'd0, 8'd0);
		u_check.end_test();

		u_check.start_test("keyboard");
		for (int k = 0; k < 3; k++)
		begin
			rng = xorshift(rng);
			word[39:32] = rng[7:0];
			rng = xorshift(rng);
			word[31:0] = rng;
			u_check.note_kbd(word);
			transfer(avr_link_pkg::REG_KBD, word, 40, rd);
			u_check.expect_commit(6'd0, 8'd0);
			transfer(avr_link_pkg::REG_KBD_STB, 40'd0, 8, rd);
			u_check.expect_commit(commit_mask(avr_link_pkg::REG_KBD_STB), 8'd0);
		end
		u_check.end_test();

		u_check.start_test("mouse_joystick");
		for (int k = 0; k < 8; k++)
		begin
			rng = xorshift(rng);
			num = avr_link_pkg::REG_MUS_X + (k % 4);
			b = rng[15:8];
			transfer(num, {32'd0, b}, 8, rd);
			u_check.expect_commit(commit_mask(num), b);
		end
		u_check.end_test();

		u_check.start_test("reset_config");
		rng = xorshift(rng);
		transfer(avr_link_pkg::REG_RST, {32'd0, rng[7:0]}, 8, rd);
		u_check.expect_commit(commit_mask(avr_link_pkg::REG_RST), 8'd0);
		rng = xorshift(rng);
		u_check.note_cfg(rng[7:0]);
		transfer(avr_link_pkg::REG_CFG0, {32'd0, rng[7:0]}, 8, rd);
		u_check.expect_commit(6'd0, 8'd0);
		transfer(avr_link_pkg::REG_MUS_Y, 40'h5a, 8, rd); // config0 must hold
		u_check.expect_commit(commit_mask(avr_link_pkg::REG_MUS_Y), 8'h5a);
		u_check.end_test();

		u_check.start_test("sd_exchange");
		u_check.note_cs_n(1'b0);
		transfer(avr_link_pkg::REG_SD_CTRL, 40'd0, 8, rd);
		u_check.expect_commit(6'd0, 8'd0);
		for (int k = 0; k < 3; k++)
		begin
			sd_wait_idle();
			rng = xorshift(rng);
			sd_reply = rng[7:0];
			b = rng[23:16];
			transfer(avr_link_pkg::REG_SD_DATA, {32'd0, b}, 8, rd);
			u_check.expect_commit(6'd0, 8'd0);
			sd_wait_idle();
			u_check.compare("mosi byte", {32'd0, b}, {32'd0, mosi_seen});
			transfer(avr_link_pkg::REG_SD_DATA, 40'hff, 8, rd); // read, starts a dummy
			u_check.expect_commit(6'd0, 8'd0);
			u_check.compare("sd reply", {32'd0, sd_reply}, {32'd0, rd[7:0]});
		end
		sd_wait_idle();
		u_check.note_cs_n(1'b1);
		transfer(avr_link_pkg::REG_SD_CTRL, 40'd1, 8, rd);
		u_check.expect_commit(6'd0, 8'd0);
		u_check.end_test();

		u_check.start_test("status_readback");
		for (int k = 0; k < 3; k++)
		begin
			transfer(8'h00, 40'd0, 8, rd);
			u_check.expect_commit(6'd0, 8'd0);
		end
		u_check.end_test();

		u_check.report();
		if (u_check.n_fail == 0 && u_check.total_errs == 0 &&
			u_evo_avr_link.u_props.err_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/avr_link_props.sv
// bound assertions for the avr link
// strobe width, strobe exclusivity, sd clock idle level
`timescale 1ns/1ps
`default_nettype none

module avr_link_props
(
	input logic       fclk,
	input logic       rst_n,
	input logic [6:0] stb,      // all commit strobes plus sd_valid
	input logic       sd_sck,
	input logic       sd_ready
);

	int err_cnt; // failed assertions so far

	initial
		err_cnt = 0;

	// no strobe stays high two cycles in a row
	stb_one_cycle: assert property (@(posedge fclk) disable iff (!rst_n)
		(stb & $past(stb)) == 7'd0)
		else
		begin
			$error("strobe held longer than one cycle");
			err_cnt++;
		end

	stb_exclusive: assert property (@(posedge fclk) disable iff (!rst_n)
		$onehot0(stb))
		else
		begin
			$error("more than one strobe high");
			err_cnt++;
		end

	// idle exchanger keeps the card clock low
	sck_idle_low: assert property (@(posedge fclk) disable iff (!rst_n)
		sd_ready |-> !sd_sck)
		else
		begin
			$error("sd_sck high while exchanger idle");
			err_cnt++;
		end

endmodule

// top scope sees the strobes, sd_valid and the exchanger side together
bind evo_avr_link avr_link_props u_props
(
	.fclk     (fclk),
	.rst_n    (rst_n),
	.stb      ({kbd_stb, mus_xstb, mus_ystb, mus_btnstb, kj_stb, genrst, sd_valid}),
	.sd_sck   (sd_sck),
	.sd_ready (sd_ready)
);

`default_nettype wire

//--- testbench/avr_link_checker.sv
// avr link checker
// records commit strobes, holds the register model, counts errors per test
`timescale 1ns/1ps
`default_nettype none

module avr_link_checker
(
	input logic                    fclk,
	input logic                    rst_n,
	input avr_link_pkg::kbd_word_t kbd_out,
	input logic                    kbd_stb,
	input avr_link_pkg::byte_t     mus_out,
	input logic                    mus_xstb,
	input logic                    mus_ystb,
	input logic                    mus_btnstb,
	input logic                    kj_stb,
	input logic                    genrst,
	input avr_link_pkg::byte_t     config0,
	input logic                    sd_cs_n
);

	avr_link_pkg::kbd_word_t kbd_model; // last 40 bits written to $10
	avr_link_pkg::byte_t     cfg_model;
	logic                    cs_n_model; // bit 0 of the last $61 write
	avr_link_pkg::kbd_word_t seen_val;  // value beside the last strobe
	logic [5:0]              seen_mask;
	logic [5:0]              stb_now;
	int                      seen_cnt;
	string                   test_name;
	int                      test_errs;
	int                      total_errs;
	int                      n_pass;
	int                      n_fail;

	assign stb_now = {kbd_stb, mus_xstb, mus_ystb, mus_btnstb, kj_stb, genrst};

	initial
	begin
		kbd_model  = '0;
		cfg_model  = '0;
		cs_n_model = 1'b1; // card deselected after reset
		seen_val   = '0;
		seen_mask  = '0;
		seen_cnt   = 0;
		test_errs  = 0;
		total_errs = 0;
		n_pass     = 0;
		n_fail     = 0;
		test_name  = "none";
	end

	// sample mid-cycle, strobes are stable
	always @(negedge fclk)
		if (rst_n && stb_now != 6'd0)
		begin
			seen_mask = seen_mask | stb_now;
			seen_cnt  = seen_cnt + 1;
			seen_val  = kbd_stb ? kbd_out : {32'd0, mus_out};
		end

	task automatic compare(input string what, input logic [39:0] exp, input logic [39:0] act);
		if (exp !== act)
		begin
			$display("Mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic fail_msg(input string msg);
		$display("Error in %s: %s", test_name, msg);
		test_errs++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		if (test_errs == 0)
		begin
			$display("test %s: pass", test_name);
			n_pass++;
		end
		else
		begin
			$display("test %s: fail, %0d errors", test_name, test_errs);
			n_fail++;
		end
		total_errs += test_errs;
	endtask

	task automatic note_kbd(input avr_link_pkg::kbd_word_t w);
		kbd_model = w;
	endtask

	task automatic note_cfg(input avr_link_pkg::byte_t b);
		cfg_model = b;
	endtask

	task automatic note_cs_n(input logic v);
		cs_n_model = v;
	endtask

	// one commit checked against the model, then the record is cleared
	task automatic expect_commit(input logic [5:0] mask, input avr_link_pkg::byte_t val);
		compare("strobes", {34'd0, mask}, {34'd0, seen_mask});
		if (mask != 6'd0 && seen_cnt != 1)
			fail_msg($sformatf("strobe pulsed %0d times instead of once", seen_cnt));
		if (mask == 6'b100000)
			compare("kbd_out", kbd_model, seen_val);
		else if (mask != 6'd0 && mask != 6'b000001)
			compare("mus_out", {32'd0, val}, seen_val);
		compare("config0", {32'd0, cfg_model}, {32'd0, config0});
		compare("sd_cs_n", {39'd0, cs_n_model}, {39'd0, sd_cs_n});
		seen_mask = '0;
		seen_cnt  = 0;
	endtask

	task automatic report();
		$display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, total_errs);
	endtask

endmodule

`default_nettype wire

//--- src/evo_avr_link.sv
// avr board-control link, top level
// pin resync, slave register block and sd byte exchanger
`timescale 1ns/1ps
`default_nettype none

module evo_avr_link #(
	parameter int SD_DIV = 2 // sd sck half period in fclk cycles
)
(
	input  logic                    fclk,
	input  logic                    rst_n,
	input  logic                    spics_n,   // avr spi
	input  logic                    spick,
	input  logic                    spido,
	output logic                    spidi,
	input  avr_link_pkg::byte_t     status_in,
	output avr_link_pkg::kbd_word_t kbd_out,
	output logic                    kbd_stb,
	output avr_link_pkg::byte_t     mus_out,
	output logic                    mus_xstb,
	output logic                    mus_ystb,
	output logic                    mus_btnstb,
	output logic                    kj_stb,
	output logic                    genrst,
	output avr_link_pkg::byte_t     config0,
	output logic                    sd_cs_n,   // sd card
	output logic                    sd_sck,
	output logic                    sd_mosi,
	input  logic                    sd_miso
);

	avr_link_pkg::byte_t sd_tx_byte;
	avr_link_pkg::byte_t sd_rx_byte;
	logic                sd_valid;
	logic                sd_ready;

	spi_link_if link ();

	spi_line_sync u_sync
	(
		.fclk    (fclk),
		.rst_n   (rst_n),
		.spics_n (spics_n),
		.spick   (spick),
		.spido   (spido),
		.link    (link)
	);

	avr_slave_regs u_regs
	(
		.fclk       (fclk),
		.rst_n      (rst_n),
		.link       (link),
		.status_in  (status_in),
		.sd_rx_byte (sd_rx_byte),
		.sd_ready   (sd_ready),
		.spidi      (spidi),
		.kbd_out    (kbd_out),
		.kbd_stb    (kbd_stb),
		.mus_out    (mus_out),
		.mus_xstb   (mus_xstb),
		.mus_ystb   (mus_ystb),
		.mus_btnstb (mus_btnstb),
		.kj_stb     (kj_stb),
		.genrst     (genrst),
		.config0    (config0),
		.sd_cs_n    (sd_cs_n),
		.sd_valid   (sd_valid),
		.sd_tx_byte (sd_tx_byte)
	);

	sd_byte_xfer #(
		.SD_DIV (SD_DIV)
	) u_sd (
		.fclk       (fclk),
		.rst_n      (rst_n),
		.sd_valid   (sd_valid),
		.sd_tx_byte (sd_tx_byte),
		.sd_ready   (sd_ready),
		.sd_rx_byte (sd_rx_byte),
		.sd_sck     (sd_sck),
		.sd_mosi    (sd_mosi),
		.sd_miso    (sd_miso)
	);

endmodule

`default_nettype wire

//--- src/sd_byte_xfer.sv
// sd card byte exchanger
// spi mode 0 master, msb first, SD_DIV fclk cycles per sck half period
`timescale 1ns/1ps
`default_nettype none

module sd_byte_xfer #(
	parameter int SD_DIV = 2 // fclk cycles per half period, 1 or more
)
(
	input  logic                fclk,
	input  logic                rst_n,
	input  logic                sd_valid,
	input  avr_link_pkg::byte_t sd_tx_byte,
	output logic                sd_ready,   // high when idle
	output avr_link_pkg::byte_t sd_rx_byte,
	output logic                sd_sck,
	output logic                sd_mosi,
	input  logic                sd_miso
);

	typedef enum logic {IDLE, SHIFT} sd_state_t;

	localparam int DIV_W = (SD_DIV > 1) ? $clog2(SD_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SD_DIV - 1);

	sd_state_t           state;
	logic [DIV_W-1:0]    div_cnt;  // paces one half period
	logic [3:0]          half_cnt; // 16 halves per byte
	avr_link_pkg::byte_t sh;       // tx out at top, rx in at bottom
	logic                miso_q;   // sampled on rising sck
	logic                half_end;
	logic                last_half;
	logic                start;

	assign half_end  = (state == SHIFT) && (div_cnt == DIV_LAST);
	assign last_half = half_end && (half_cnt == 4'd15);
	assign start     = sd_valid && sd_ready;
	assign sd_ready  = (state == IDLE);
	assign sd_mosi   = sh[7];

	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
		begin
			state    <= IDLE;
			div_cnt  <= '0;
			half_cnt <= '0;
			sd_sck   <= 1'b0;
			sh       <= 8'hff; // mosi idles high
			miso_q   <= 1'b0;
		end
		else if (start)
		begin
			state    <= SHIFT;
			div_cnt  <= '0;
			half_cnt <= '0;
			sh       <= sd_tx_byte; // msb on mosi right away
		end
		else if (half_end)
		begin
			div_cnt  <= '0;
			sd_sck   <= ~sd_sck;
			half_cnt <= half_cnt + 4'd1;
			if (!sd_sck)
				miso_q <= sd_miso;             // rising edge, sample
			else
				sh <= {sh[6:0], miso_q};       // falling edge, next bit out
			if (last_half)
			begin
				state <= IDLE;
				sh    <= 8'hff;
			end
		end
		else if (state == SHIFT)
			div_cnt <= div_cnt + DIV_W'(1);

	// reply held until the next exchange ends
	always_ff @(posedge fclk)
		if (last_half)
			sd_rx_byte <= {sh[6:0], miso_q};

endmodule

`default_nettype wire

//--- src/avr_slave_regs.sv
// avr spi slave registers
// number phase with cs high, data phase with cs low, commit on cs release
`timescale 1ns/1ps
`default_nettype none

module avr_slave_regs
(
	input  logic                      fclk,
	input  logic                      rst_n,
	spi_link_if.slave                 link,
	input  avr_link_pkg::byte_t       status_in,  // shown during number phase
	input  avr_link_pkg::byte_t       sd_rx_byte,
	input  logic                      sd_ready,
	output logic                      spidi,
	output avr_link_pkg::kbd_word_t   kbd_out,
	output logic                      kbd_stb,
	output avr_link_pkg::byte_t       mus_out,
	output logic                      mus_xstb,
	output logic                      mus_ystb,
	output logic                      mus_btnstb,
	output logic                      kj_stb,
	output logic                      genrst,     // cpu reset pulse
	output avr_link_pkg::byte_t       config0,
	output logic                      sd_cs_n,
	output logic                      sd_valid,   // start request to sd exchanger
	output avr_link_pkg::byte_t       sd_tx_byte
);

	avr_link_pkg::reg_num_t  regnum;     // current register number
	avr_link_pkg::kbd_word_t kbd_reg;
	avr_link_pkg::byte_t     common_reg; // shared shift-in for byte registers
	avr_link_pkg::byte_t     shift_out;  // readback shifter
	avr_link_pkg::byte_t     rd_data;
	logic [3:0]              grp;
	logic                    shift_en;

	logic sel_kbdreg, sel_kbdstb;
	logic sel_musx, sel_musy, sel_musbtn, sel_kj;
	logic sel_rst, sel_cfg0, sel_sddata, sel_sdctrl;
	logic sel_common;

	// register number, lsb first while cs high
	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
			regnum <= '0;
		else if (link.cs_rise)
			regnum <= '0; // next transfer starts clean
		else if (link.scs_n && link.sck_rise)
			regnum <= {link.sdo, regnum[7:1]};

	// decode: high nibble picks the group
	assign grp = regnum[7:4];

	assign sel_kbdreg = (grp == avr_link_pkg::REG_KBD[7:4]) &&
		(regnum[0] == avr_link_pkg::REG_KBD[0]);
	assign sel_kbdstb = (grp == avr_link_pkg::REG_KBD_STB[7:4]) &&
		(regnum[0] == avr_link_pkg::REG_KBD_STB[0]);

	assign sel_musx   = (grp == avr_link_pkg::REG_MUS_X[7:4]) &&
		(regnum[1:0] == avr_link_pkg::REG_MUS_X[1:0]);
	assign sel_musy   = (grp == avr_link_pkg::REG_MUS_Y[7:4]) &&
		(regnum[1:0] == avr_link_pkg::REG_MUS_Y[1:0]);
	assign sel_musbtn = (grp == avr_link_pkg::REG_MUS_BTN[7:4]) &&
		(regnum[1:0] == avr_link_pkg::REG_MUS_BTN[1:0]);
	assign sel_kj     = (grp == avr_link_pkg::REG_KJ[7:4]) &&
		(regnum[1:0] == avr_link_pkg::REG_KJ[1:0]);

	assign sel_rst  = (grp == avr_link_pkg::REG_RST[7:4]);  // whole group
	assign sel_cfg0 = (grp == avr_link_pkg::REG_CFG0[7:4]); // whole group

	assign sel_sddata = (grp == avr_link_pkg::REG_SD_DATA[7:4]) &&
		(regnum[0] == avr_link_pkg::REG_SD_DATA[0]);
	assign sel_sdctrl = (grp == avr_link_pkg::REG_SD_CTRL[7:4]) &&
		(regnum[0] == avr_link_pkg::REG_SD_CTRL[0]);

	// byte registers all share one shifter
	assign sel_common = sel_musx || sel_musy || sel_musbtn || sel_kj ||
		sel_cfg0 || sel_sddata || sel_sdctrl;

	assign shift_en = !link.scs_n && link.sck_rise; // data phase bit

	// data shift-in, lsb first
	always_ff @(posedge fclk)
	begin
		if (shift_en && sel_kbdreg)
			kbd_reg <= {link.sdo, kbd_reg[39:1]};
		if (shift_en && sel_common)
			common_reg <= {link.sdo, common_reg[7:1]};
	end

	// latched outputs, loaded at commit
	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
		begin
			config0 <= '0;
			sd_cs_n <= 1'b1; // card deselected
		end
		else if (link.cs_rise)
		begin
			if (sel_cfg0)
				config0 <= common_reg;
			if (sel_sdctrl)
				sd_cs_n <= common_reg[0];
		end

	// what the avr reads in the data phase
	always_comb
	begin
		if (sel_sddata)
			rd_data = sd_rx_byte;            // last card reply
		else if (sel_sdctrl)
			rd_data = {~sd_ready, 7'd0};     // busy flag
		else
			rd_data = '0;
	end

	// readback shifter, status after release, register after select
	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
			shift_out <= '0;
		else if (link.cs_rise)
			shift_out <= status_in;
		else if (link.cs_fall)
			shift_out <= rd_data;
		else if (link.sck_rise)
			shift_out <= {1'b0, shift_out[7:1]};

	assign spidi = shift_out[0];

	// commit strobes, combinational off the release event
	assign kbd_out    = kbd_reg;
	assign kbd_stb    = sel_kbdstb && link.cs_rise;
	assign mus_out    = common_reg;
	assign mus_xstb   = sel_musx   && link.cs_rise;
	assign mus_ystb   = sel_musy   && link.cs_rise;
	assign mus_btnstb = sel_musbtn && link.cs_rise;
	assign kj_stb     = sel_kj     && link.cs_rise;
	assign genrst     = sel_rst    && link.cs_rise;

	// dropped by the exchanger if still busy
	assign sd_valid   = sel_sddata && link.cs_rise;
	assign sd_tx_byte = common_reg;

endmodule

`default_nettype wire

//--- src/spi_line_sync.sv
// avr spi pin resynchronizer
// two flops per pin, one extra stage on cs and sck for edge events
`timescale 1ns/1ps
`default_nettype none

module spi_line_sync
(
	input  logic     fclk,
	input  logic     rst_n,
	input  logic     spics_n, // avr pins, async to fclk
	input  logic     spick,
	input  logic     spido,
	spi_link_if.sync link
);

	logic [2:0] cs_sync; // [1] is the usable level, [2] the previous one
	logic [2:0] ck_sync;
	logic [1:0] do_sync; // no edge needed on data

	always_ff @(posedge fclk or negedge rst_n)
		if (!rst_n)
		begin
			cs_sync <= 3'b111; // idle cs high
			ck_sync <= 3'b000; // idle sck low
			do_sync <= 2'b00;
		end
		else
		begin
			cs_sync <= {cs_sync[1:0], spics_n};
			ck_sync <= {ck_sync[1:0], spick};
			do_sync <= {do_sync[0], spido};
		end

	assign link.scs_n = cs_sync[1];
	assign link.sdo   = do_sync[1];

	// events 2..3 fclk after the pin moves
	assign link.sck_rise = ~ck_sync[2] &  ck_sync[1];
	assign link.cs_rise  = ~cs_sync[2] &  cs_sync[1]; // end of transfer
	assign link.cs_fall  =  cs_sync[2] & ~cs_sync[1];

endmodule

`default_nettype wire

//--- src/spi_link_if.sv
// synchronized avr spi lines and edge events, all in the fclk domain
`timescale 1ns/1ps
`default_nettype none

interface spi_link_if;

	logic scs_n;    // chip select level, resynced
	logic sdo;      // avr data out, resynced
	logic sck_rise; // one-cycle event
	logic cs_rise;  // cs_n 0->1, commit
	logic cs_fall;  // cs_n 1->0, data phase begins

	// synchronizer side
	modport sync
	(
		output scs_n, sdo, sck_rise, cs_rise, cs_fall
	);

	// register block side
	modport slave
	(
		input scs_n, sdo, sck_rise, cs_rise, cs_fall
	);

endinterface

`default_nettype wire

//--- src/avr_link_pkg.sv
// avr link shared definitions
// byte and word types, avr register numbers
`default_nettype none

package avr_link_pkg;

	typedef logic [7:0]  byte_t;     // one byte on the link, sd data or config
	typedef logic [7:0]  reg_num_t;  // avr register number
	typedef logic [39:0] kbd_word_t; // keyboard matrix image

	// keyboard group
	localparam reg_num_t REG_KBD     = 8'h10; // 40-bit shift-in
	localparam reg_num_t REG_KBD_STB = 8'h11; // commit to keyboard

	// mouse and joystick group, low two bits select
	localparam reg_num_t REG_MUS_X   = 8'h20;
	localparam reg_num_t REG_MUS_Y   = 8'h21;
	localparam reg_num_t REG_MUS_BTN = 8'h22;
	localparam reg_num_t REG_KJ      = 8'h23; // kempston joystick

	// whole group, low nibble ignored
	localparam reg_num_t REG_RST     = 8'h30; // cpu reset pulse
	localparam reg_num_t REG_CFG0    = 8'h50; // config byte

	// sd card port
	localparam reg_num_t REG_SD_DATA = 8'h60; // write starts exchange, read gives reply
	localparam reg_num_t REG_SD_CTRL = 8'h61; // bit 0 cs_n, bit 7 busy on read

endpackage

`default_nettype wire
